// ==== hw/elk_mem_pkg.sv ====
// Electron glue memory map definitions
`default_nettype none

package elk_mem_pkg;

	////////////////////////////////////////////////////////////
	// bus and bank geometry
	////////////////////////////////////////////////////////////

	// byte offset inside one 16 KB sideways bank
	localparam int bank_addr_bits = 14;
	// core external address
	localparam int bus_addr_bits = 19;
	// rom has 7 slots of 16 KB
	localparam int rom_slot_bits = 3;
	// ram has 8 slots
	localparam int ram_slot_bits = 3;
	// bank selector bits above the offset
	localparam int bank_sel_bits = bus_addr_bits - bank_addr_bits;
	// array address widths
	localparam int rom_addr_bits = rom_slot_bits + bank_addr_bits;
	localparam int ram_addr_bits = ram_slot_bits + bank_addr_bits;

	localparam int rom_words = 114688;
	localparam int ram_words = 131072;

	// decoded target of a bus address
	typedef enum logic [1:0] {
		region_rom,
		region_ram,
		region_none
	} region_e;

	// core bus request, driven every cycle
	typedef struct packed {
		logic [bus_addr_bits-1:0] addr;
		logic                     we_n;
		logic [7:0]               wdata;
	} mem_req_t;

	// single loader byte
	typedef struct packed {
		logic                     valid;
		logic [rom_addr_bits-1:0] addr;
		logic [7:0]               data;
	} rom_load_t;

endpackage

`default_nettype wire

// ==== hw/elk_io_pkg.sv ====
// Electron glue I/O definitions
`default_nettype none

package elk_io_pkg;

	////////////////////////////////////////////////////////////
	// tape slicer
	////////////////////////////////////////////////////////////

	localparam int adc_bits = 12;
	localparam int slice_window = 512;
	localparam int slice_window_log2 = 9;
	// half width of the dead band around the average
	localparam int slice_hyst = 100;
	// running sum of a full window
	localparam int slice_sum_bits = adc_bits + slice_window_log2;
	// two spare bits so avg +/- hyst never wraps
	localparam int slice_cmp_bits = adc_bits + 2;

	////////////////////////////////////////////////////////////
	// apb and registers
	////////////////////////////////////////////////////////////

	localparam int apb_addr_bits = 8;
	localparam int apb_data_bits = 32;
	localparam logic [apb_addr_bits-1:0] reg_ctrl_addr = 8'h00;
	localparam logic [apb_addr_bits-1:0] reg_status_addr = 8'h04;

	// joystick
	localparam int joy_fire_bit = 4;
	localparam int joy_axis_bits = 8;

	typedef struct packed {
		logic                     psel;
		logic                     penable;
		logic                     pwrite;
		logic [apb_addr_bits-1:0] paddr;
		logic [apb_data_bits-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [apb_data_bits-1:0] prdata;
		logic                     pready;
		logic                     pslverr;
	} apb_rsp_t;

	typedef struct packed {
		logic core_hold;
		logic swap_joy;
		logic tape_from_adc;
	} glue_cfg_t;

	typedef struct packed {
		logic                valid;
		logic [adc_bits-1:0] data;
	} adc_sample_t;

	// analog: y in [15:8], x in [7:0], both signed
	typedef struct packed {
		logic [15:0] digital;
		logic [15:0] analog;
	} joy_in_t;

	typedef struct packed {
		logic                     fire;
		logic [joy_axis_bits-1:0] x;
		logic [joy_axis_bits-1:0] y;
	} joy_out_t;

	typedef enum logic [1:0] {
		reg_ctrl,
		reg_status,
		reg_bad
	} reg_e;

endpackage

`default_nettype wire

// ==== hw/elk_ctrl_regs.sv ====
// APB configuration and status registers
`timescale 1ns/1ps
`default_nettype none

module elk_ctrl_regs (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  elk_io_pkg::apb_req_t  apb_req,
	output elk_io_pkg::apb_rsp_t  apb_rsp,
	input  logic                  cas_bit,
	output elk_io_pkg::glue_cfg_t cfg
);

	elk_io_pkg::reg_e      reg_sel;
	elk_io_pkg::glue_cfg_t ctrl_q;
	logic                  access;
	logic                  wr_ctrl;
	logic                  bad_op;
	logic [elk_io_pkg::apb_data_bits-1:0] rd_data;

	////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////

	always_comb begin
		case (apb_req.paddr)
			elk_io_pkg::reg_ctrl_addr:   reg_sel = elk_io_pkg::reg_ctrl;
			elk_io_pkg::reg_status_addr: reg_sel = elk_io_pkg::reg_status;
			default:                     reg_sel = elk_io_pkg::reg_bad;
		endcase
	end

	// access phase, pready is always high
	assign access = apb_req.psel & apb_req.penable;
	// only ctrl takes writes
	assign wr_ctrl = access & apb_req.pwrite & (reg_sel == elk_io_pkg::reg_ctrl);
	// unknown offset, or a write to read-only status
	assign bad_op = (reg_sel == elk_io_pkg::reg_bad) |
		((reg_sel == elk_io_pkg::reg_status) & apb_req.pwrite);

	// ctrl register, written at end of access phase
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_q <= '0;
		end else if (wr_ctrl) begin
			ctrl_q.core_hold     <= apb_req.pwdata[0];
			ctrl_q.swap_joy      <= apb_req.pwdata[1];
			ctrl_q.tape_from_adc <= apb_req.pwdata[2];
		end
	end

	////////////////////////////////////////////////////////////
	// read side
	////////////////////////////////////////////////////////////

	always_comb begin
		rd_data = '0;
		case (reg_sel)
			elk_io_pkg::reg_ctrl: begin
				rd_data[2:0] = {ctrl_q.tape_from_adc, ctrl_q.swap_joy, ctrl_q.core_hold};
			end
			elk_io_pkg::reg_status: begin
				// bit0 cassette, bit1 core held
				rd_data[1:0] = {ctrl_q.core_hold, cas_bit};
			end
			default: rd_data = '0;
		endcase
	end

	assign apb_rsp.prdata  = rd_data;
	assign apb_rsp.pready  = 1'b1;
	assign apb_rsp.pslverr = access & bad_op;

	assign cfg = ctrl_q;

	// enable only ever rises inside a selected transfer
	apb_penable_in_psel: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		$rose(apb_req.penable) |-> apb_req.psel
	);

	// every setup phase meets a ready access phase
	apb_pready_held: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		(apb_req.psel && !apb_req.penable) |=>
			(apb_req.psel && apb_req.penable && apb_rsp.pready)
	);

endmodule

`default_nettype wire

// ==== hw/elk_mem_map.sv ====
// Sideways ROM and RAM memory map
`timescale 1ns/1ps
`default_nettype none

module elk_mem_map (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  elk_mem_pkg::mem_req_t  mem_req,
	input  elk_mem_pkg::rom_load_t rom_load,
	input  logic                   load_en,
	output logic [7:0]             rdata
);

	logic [elk_mem_pkg::bank_sel_bits-1:0] bank;
	elk_mem_pkg::region_e                  region;
	elk_mem_pkg::region_e                  region_q;
	logic [elk_mem_pkg::rom_slot_bits-1:0] rom_slot;
	logic [elk_mem_pkg::ram_slot_bits-1:0] ram_slot;
	logic [elk_mem_pkg::rom_addr_bits-1:0] rom_addr;
	logic [elk_mem_pkg::ram_addr_bits-1:0] ram_addr;
	logic                                  rom_we;
	logic                                  ram_we;
	logic                                  we_n_q;
	logic [7:0]                            rom_q;
	logic [7:0]                            ram_q;

	logic [7:0] rom_mem [elk_mem_pkg::rom_words];
	logic [7:0] ram_mem [elk_mem_pkg::ram_words];

	////////////////////////////////////////////////////////////
	// bank decode
	////////////////////////////////////////////////////////////

	assign bank = mem_req.addr[elk_mem_pkg::bus_addr_bits-1:elk_mem_pkg::bank_addr_bits];

	always_comb begin
		region   = elk_mem_pkg::region_none;
		rom_slot = '0;
		ram_slot = '0;
		if (bank[4]) begin
			// 1_00_xx and 1_01_xx are ram, 1_1x_xx empty
			if (!bank[3]) begin
				region   = elk_mem_pkg::region_ram;
				ram_slot = bank[2:0];
			end
		end else begin
			case (bank[3:0])
				4'b01_00: begin
					region   = elk_mem_pkg::region_rom;
					rom_slot = 3'd0;
				end
				// os image spans two banks
				4'b10_00, 4'b10_01: begin
					region   = elk_mem_pkg::region_rom;
					rom_slot = 3'd1;
				end
				// basic, also two banks
				4'b10_10, 4'b10_11: begin
					region   = elk_mem_pkg::region_rom;
					rom_slot = 3'd2;
				end
				4'b11_00, 4'b11_01, 4'b11_10, 4'b11_11: begin
					region   = elk_mem_pkg::region_rom;
					rom_slot = 3'd3 + {1'b0, bank[1:0]};
				end
				default: region = elk_mem_pkg::region_none;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// rom, loader owns the port while the core is held
	////////////////////////////////////////////////////////////

	assign rom_addr = load_en ? rom_load.addr : {rom_slot, mem_req.addr[13:0]};
	assign rom_we = load_en & rom_load.valid & (rom_load.addr < elk_mem_pkg::rom_words);

	always_ff @(posedge clk_sys) begin
		if (rom_we)
			rom_mem[rom_addr] <= rom_load.data;
		rom_q <= rom_mem[rom_addr];
	end

	////////////////////////////////////////////////////////////
	// ram, one write per falling edge of we_n
	////////////////////////////////////////////////////////////

	assign ram_addr = {ram_slot, mem_req.addr[13:0]};
	assign ram_we = (region == elk_mem_pkg::region_ram) & we_n_q & ~mem_req.we_n;

	always_ff @(posedge clk_sys) begin
		if (ram_we)
			ram_mem[ram_addr] <= mem_req.wdata;
		ram_q <= ram_mem[ram_addr];
	end

	// previous strobe and region of the pending read
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			we_n_q   <= 1'b1;
			region_q <= elk_mem_pkg::region_none;
		end else begin
			we_n_q   <= mem_req.we_n;
			region_q <= region;
		end
	end

	// unmapped reads give zero
	always_comb begin
		case (region_q)
			elk_mem_pkg::region_rom: rdata = rom_q;
			elk_mem_pkg::region_ram: rdata = ram_q;
			default:                 rdata = 8'h00;
		endcase
	end

	// a held-low strobe never writes twice
	ram_we_single: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		ram_we |=> !ram_we
	);

endmodule

`default_nettype wire

// ==== hw/elk_tape_slicer.sv ====
// ADC tape level slicer
`timescale 1ns/1ps
`default_nettype none

module elk_tape_slicer (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  elk_io_pkg::adc_sample_t adc_in,
	output logic                    cas_bit
);

	logic [elk_io_pkg::adc_bits-1:0]          win_mem [elk_io_pkg::slice_window];
	logic [elk_io_pkg::slice_window_log2-1:0] wr_ptr;
	logic [elk_io_pkg::slice_window_log2-1:0] rd_ptr;
	logic                                     win_full;
	logic [elk_io_pkg::adc_bits-1:0]          head_q;
	logic [elk_io_pkg::adc_bits-1:0]          oldest;
	logic [elk_io_pkg::slice_sum_bits-1:0]    sum_q;
	logic [elk_io_pkg::adc_bits-1:0]          avg;
	logic signed [elk_io_pkg::slice_cmp_bits-1:0] samp;
	logic signed [elk_io_pkg::slice_cmp_bits-1:0] thr_lo;
	logic signed [elk_io_pkg::slice_cmp_bits-1:0] thr_hi;

	////////////////////////////////////////////////////////////
	// window store
	////////////////////////////////////////////////////////////

	// read one ahead so head_q always holds mem[wr_ptr]
	assign rd_ptr = adc_in.valid ? wr_ptr + 1'b1 : wr_ptr;

	always_ff @(posedge clk_sys) begin
		if (adc_in.valid)
			win_mem[wr_ptr] <= adc_in.data;
		head_q <= win_mem[rd_ptr];
	end

	// until the first wrap the leaving sample is a zero
	assign oldest = win_full ? head_q : '0;

	// truncated mean, sum >> 9
	assign avg = sum_q[elk_io_pkg::slice_sum_bits-1:elk_io_pkg::slice_window_log2];

	////////////////////////////////////////////////////////////
	// thresholds
	////////////////////////////////////////////////////////////

	assign samp   = {2'b00, adc_in.data};
	// may go negative near zero
	assign thr_lo = $signed({2'b00, avg}) -
		elk_io_pkg::slice_cmp_bits'(elk_io_pkg::slice_hyst);
	assign thr_hi = $signed({2'b00, avg}) +
		elk_io_pkg::slice_cmp_bits'(elk_io_pkg::slice_hyst);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			win_full <= 1'b0;
			sum_q    <= '0;
			cas_bit  <= 1'b0;
		end else if (adc_in.valid) begin
			wr_ptr <= wr_ptr + 1'b1;
			if (&wr_ptr)
				win_full <= 1'b1;
			sum_q <= sum_q - oldest + adc_in.data;
			// low level gives 1, high level gives 0, band holds
			if (samp < thr_lo)
				cas_bit <= 1'b1;
			else if (samp > thr_hi)
				cas_bit <= 1'b0;
		end
	end

	// bit only moves right after a sample
	cas_bit_after_valid: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		!$stable(cas_bit) |-> $past(adc_in.valid)
	);

endmodule

`default_nettype wire

// ==== hw/elk_input_router.sv ====
// Joystick and tape source routing
`timescale 1ns/1ps
`default_nettype none

module elk_input_router (
	input  elk_io_pkg::glue_cfg_t cfg,
	input  elk_io_pkg::joy_in_t   joy_a,
	input  elk_io_pkg::joy_in_t   joy_b,
	input  logic                  cas_bit,
	input  logic                  tape_file_bit,
	output elk_io_pkg::joy_out_t  joy_1,
	output elk_io_pkg::joy_out_t  joy_2,
	output logic                  tape_in
);

	elk_io_pkg::joy_in_t sel_1;
	elk_io_pkg::joy_in_t sel_2;

	// fire bit and inverted axes of one pad
	function automatic elk_io_pkg::joy_out_t map_joy(input elk_io_pkg::joy_in_t j);
		elk_io_pkg::joy_out_t o;
		o.fire = j.digital[elk_io_pkg::joy_fire_bit];
		// 127 - axis, wraps mod 256
		o.x = 8'd127 - j.analog[7:0];
		o.y = 8'd127 - j.analog[15:8];
		return o;
	endfunction

	////////////////////////////////////////////////////////////
	// player swap
	////////////////////////////////////////////////////////////

	assign sel_1 = cfg.swap_joy ? joy_b : joy_a;
	assign sel_2 = cfg.swap_joy ? joy_a : joy_b;

	assign joy_1 = map_joy(sel_1);
	assign joy_2 = map_joy(sel_2);

	// tape from adc slicer or from file player
	assign tape_in = cfg.tape_from_adc ? cas_bit : tape_file_bit;

endmodule

`default_nettype wire

// ==== hw/elk_glue_top.sv ====
// Electron glue logic top level
`timescale 1ns/1ps
`default_nettype none

module elk_glue_top (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  elk_io_pkg::apb_req_t    apb_req,
	output elk_io_pkg::apb_rsp_t    apb_rsp,
	input  elk_mem_pkg::mem_req_t   mem_req,
	output logic [7:0]              mem_rdata,
	input  elk_mem_pkg::rom_load_t  rom_load,
	input  elk_io_pkg::adc_sample_t adc_in,
	input  logic                    tape_file_bit,
	input  elk_io_pkg::joy_in_t     joy_a,
	input  elk_io_pkg::joy_in_t     joy_b,
	output elk_io_pkg::joy_out_t    joy_1,
	output elk_io_pkg::joy_out_t    joy_2,
	output logic                    tape_in,
	output logic                    core_reset
);

	elk_io_pkg::glue_cfg_t cfg;
	logic                  cas_bit;

	// config and status over apb
	elk_ctrl_regs i_elk_ctrl_regs (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.cas_bit (cas_bit),
		.cfg     (cfg)
	);

	// loader only while the core is held
	elk_mem_map i_elk_mem_map (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.mem_req  (mem_req),
		.rom_load (rom_load),
		.load_en  (cfg.core_hold),
		.rdata    (mem_rdata)
	);

	elk_tape_slicer i_elk_tape_slicer (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.adc_in  (adc_in),
		.cas_bit (cas_bit)
	);

	elk_input_router i_elk_input_router (
		.cfg           (cfg),
		.joy_a         (joy_a),
		.joy_b         (joy_b),
		.cas_bit       (cas_bit),
		.tape_file_bit (tape_file_bit),
		.joy_1         (joy_1),
		.joy_2         (joy_2),
		.tape_in       (tape_in)
	);

	// hold the core in reset during rom load
	assign core_reset = cfg.core_hold;

endmodule

`default_nettype wire

// ==== sim/elk_glue_model.svh ====
// Glue logic reference model

`ifndef ELK_GLUE_MODEL_SVH
`define ELK_GLUE_MODEL_SVH

	////////////////////////////////////////////////////////////
	// model state
	////////////////////////////////////////////////////////////

	// bytes as loaded or written, indexed slot * 16 KB + offset
	logic [7:0] rom_model [elk_mem_pkg::rom_words];
	logic [7:0] ram_model [elk_mem_pkg::ram_words];

	// slicer window, oldest entry at win_pos
	int   win_model [elk_io_pkg::slice_window];
	int   win_sum;
	int   win_pos;
	logic cas_model;

	elk_io_pkg::glue_cfg_t cfg_model;

	// state right after rst_n
	task automatic model_reset();
		foreach (win_model[i])
			win_model[i] = 0;
		win_sum   = 0;
		win_pos   = 0;
		cas_model = 1'b0;
		cfg_model = '0;
	endtask

	////////////////////////////////////////////////////////////
	// memory map
	////////////////////////////////////////////////////////////

	// slot table for banks with the top bit clear, -1 when empty
	function automatic int rom_slot_of(input int bank);
		if (bank == 5'b0_01_00)
			return 0;
		if (bank == 5'b0_10_00 || bank == 5'b0_10_01)
			return 1;
		if (bank == 5'b0_10_10 || bank == 5'b0_10_11)
			return 2;
		// four single-bank slots 3 to 6
		if (bank >= 5'b0_11_00 && bank <= 5'b0_11_11)
			return 3 + (bank - 5'b0_11_00);
		return -1;
	endfunction

	function automatic logic [7:0] expect_read(input logic [18:0] addr);
		int bank;
		int off;
		int slot;
		bank = addr[18:14];
		off  = addr[13:0];
		if (bank < 16) begin
			slot = rom_slot_of(bank);
			if (slot < 0)
				return 8'h00;
			return rom_model[slot * (1 << elk_mem_pkg::bank_addr_bits) + off];
		end
		// 1_00_00 up to 1_01_11 is ram, slot from low bank bits
		if (bank < 24)
			return ram_model[(bank - 16) * (1 << elk_mem_pkg::bank_addr_bits) + off];
		return 8'h00;
	endfunction

	////////////////////////////////////////////////////////////
	// slicer and router
	////////////////////////////////////////////////////////////

	// one accepted sample, returns the new cassette bit
	function automatic logic slice_step(input int s);
		int avg;
		avg = win_sum / elk_io_pkg::slice_window;
		if (s < avg - elk_io_pkg::slice_hyst)
			cas_model = 1'b1;
		else if (s > avg + elk_io_pkg::slice_hyst)
			cas_model = 1'b0;
		// oldest leaves, new sample enters
		win_sum = win_sum - win_model[win_pos] + s;
		win_model[win_pos] = s;
		win_pos = (win_pos + 1) % elk_io_pkg::slice_window;
		return cas_model;
	endfunction

	function automatic elk_io_pkg::joy_out_t expect_joy(input elk_io_pkg::joy_in_t j);
		elk_io_pkg::joy_out_t o;
		int ax;
		int ay;
		int rx;
		int ry;
		ax = $signed(j.analog[7:0]);
		ay = $signed(j.analog[15:8]);
		rx = 127 - ax;
		ry = 127 - ay;
		o.fire = j.digital[4];
		o.x = rx[7:0];
		o.y = ry[7:0];
		return o;
	endfunction

	function automatic logic [31:0] ctrl_word();
		return {29'd0, cfg_model.tape_from_adc, cfg_model.swap_joy, cfg_model.core_hold};
	endfunction

	function automatic logic [31:0] status_word();
		return {30'd0, cfg_model.core_hold, cas_model};
	endfunction

`endif

// ==== sim/elk_glue_tb.sv ====
// Glue logic testbench
`timescale 1ns/1ps
`default_nettype none

module elk_glue_tb;

	////////////////////////////////////////////////////////////
	// test sizes and cycle budget
	////////////////////////////////////////////////////////////

	localparam int apb_ops   = 24;
	localparam int n_offs    = 8;
	localparam int rom_slots = 7;
	localparam int ram_slots = 8;
	localparam int ram_extra = 40;
	localparam int mem_reads = 120;
	localparam int n_samples = 1500;
	// samples from here on use the file source
	localparam int file_from = 1000;
	localparam int joy_vecs  = 64;

	// apb transfer is 3 cycles with the idle gap, read 2, write pulse up to 5
	localparam int cyc_reset = 6;
	localparam int cyc_regs  = (apb_ops * 2 + 4) * 3;
	localparam int cyc_rom   = 8 + rom_slots * n_offs + n_offs + 2 + mem_reads * 4;
	localparam int cyc_ram   = (ram_slots * n_offs + ram_extra) * 5 + mem_reads * 2;
	localparam int cyc_slice = 6 + n_samples * 5;
	localparam int cyc_joy   = 6 + joy_vecs * 2;
	localparam int cyc_plan  = cyc_reset + cyc_regs + cyc_rom + cyc_ram + cyc_slice + cyc_joy;
	localparam int cycle_limit = cyc_plan * 3 / 2;

	logic                    clk_sys;
	logic                    rst_n;
	elk_io_pkg::apb_req_t    apb_req;
	elk_io_pkg::apb_rsp_t    apb_rsp;
	elk_mem_pkg::mem_req_t   mem_req;
	logic [7:0]              mem_rdata;
	elk_mem_pkg::rom_load_t  rom_load;
	elk_io_pkg::adc_sample_t adc_in;
	logic                    tape_file_bit;
	elk_io_pkg::joy_in_t     joy_a;
	elk_io_pkg::joy_in_t     joy_b;
	elk_io_pkg::joy_out_t    joy_1;
	elk_io_pkg::joy_out_t    joy_2;
	logic                    tape_in;
	logic                    core_reset;

	int          seed;
	int          errors;
	int          checks;
	int          tests_run;
	int          tests_failed;
	int          cycles = 0;
	// shared bank offsets, keeps reads on written bytes
	logic [13:0] offs [n_offs];

	`include "elk_glue_model.svh"

	elk_glue_top i_elk_glue_top (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.apb_req       (apb_req),
		.apb_rsp       (apb_rsp),
		.mem_req       (mem_req),
		.mem_rdata     (mem_rdata),
		.rom_load      (rom_load),
		.adc_in        (adc_in),
		.tape_file_bit (tape_file_bit),
		.joy_a         (joy_a),
		.joy_b         (joy_b),
		.joy_1         (joy_1),
		.joy_2         (joy_2),
		.tape_in       (tape_in),
		.core_reset    (core_reset)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys)
		cycles <= cycles + 1;

	// hang guard
	initial begin
		wait (cycles >= cycle_limit);
		$display("timeout: run did not finish within %0d cycles", cycle_limit);
		$display("Test FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_rdata(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch %s expected %h actual %h", name, exp, act);
		end
	endtask

	// full compares prdata too, otherwise only pready and pslverr
	task automatic check_apb(input string name, input elk_io_pkg::apb_rsp_t exp,
			input elk_io_pkg::apb_rsp_t act, input logic full);
		checks++;
		if ((full && act !== exp) ||
				act.pready !== exp.pready || act.pslverr !== exp.pslverr) begin
			errors++;
			$display("mismatch %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_joy(input string name, input elk_io_pkg::joy_out_t exp,
			input elk_io_pkg::joy_out_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic report_test(input string name, input int err_start);
		tests_run++;
		if (errors > err_start) begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_start);
		end else begin
			$display("test %s: passed", name);
		end
	endtask

	function automatic elk_io_pkg::apb_rsp_t expect_rsp(input logic [31:0] data, input logic err);
		elk_io_pkg::apb_rsp_t r;
		r.prdata  = data;
		r.pready  = 1'b1;
		r.pslverr = err;
		return r;
	endfunction

	////////////////////////////////////////////////////////////
	// bus drivers
	////////////////////////////////////////////////////////////

	// setup, access, then idle; rsp sampled mid access phase
	task automatic apb_xfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
			output elk_io_pkg::apb_rsp_t rsp);
		@(posedge clk_sys);
		apb_req.psel    <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite  <= write;
		apb_req.paddr   <= addr;
		apb_req.pwdata  <= wdata;
		@(posedge clk_sys);
		apb_req.penable <= 1'b1;
		@(negedge clk_sys);
		rsp = apb_rsp;
		@(posedge clk_sys);
		apb_req.psel    <= 1'b0;
		apb_req.penable <= 1'b0;
	endtask

	task automatic ctrl_write(input logic [31:0] wd);
		elk_io_pkg::apb_rsp_t rsp;
		apb_xfer(1'b1, elk_io_pkg::reg_ctrl_addr, wd, rsp);
		cfg_model.core_hold     = wd[0];
		cfg_model.swap_joy      = wd[1];
		cfg_model.tape_from_adc = wd[2];
		check_apb("ctrl write", expect_rsp(32'd0, 1'b0), rsp, 1'b0);
	endtask

	// data shows up one cycle after the address
	task automatic mem_read(input logic [18:0] addr, output logic [7:0] data);
		@(posedge clk_sys);
		mem_req.addr  <= addr;
		mem_req.we_n  <= 1'b1;
		mem_req.wdata <= 8'h00;
		@(posedge clk_sys);
		@(negedge clk_sys);
		data = mem_rdata;
	endtask

	// one low pulse of we_n, held for low_cycles
	task automatic ram_write(input logic [2:0] slot, input logic [13:0] off,
			input logic [7:0] data, input int low_cycles);
		@(posedge clk_sys);
		mem_req.addr  <= {2'b10, slot, off};
		mem_req.we_n  <= 1'b0;
		mem_req.wdata <= data;
		ram_model[slot * (1 << elk_mem_pkg::bank_addr_bits) + off] = data;
		repeat (low_cycles) @(posedge clk_sys);
		mem_req.we_n  <= 1'b1;
	endtask

	task automatic rom_load_word(input int la, input logic [7:0] data);
		@(posedge clk_sys);
		rom_load.valid <= 1'b1;
		rom_load.addr  <= la[16:0];
		rom_load.data  <= data;
	endtask

	// random reads over the lowest n_banks banks
	task automatic map_reads(input string name, input int n_banks);
		int          i;
		logic [4:0]  bank;
		logic [18:0] addr;
		logic [7:0]  got;
		for (i = 0; i < mem_reads; i++) begin
			bank = $unsigned($random(seed)) % n_banks;
			addr = {bank, offs[$unsigned($random(seed)) % n_offs]};
			mem_read(addr, got);
			check_rdata(name, expect_read(addr), got);
		end
	endtask

	////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////

	task automatic test_regs();
		int                   err_start;
		int                   i;
		logic [31:0]          wd;
		logic [7:0]           bad;
		elk_io_pkg::apb_rsp_t rsp;
		err_start = errors;
		for (i = 0; i < apb_ops; i++) begin
			wd = $random(seed);
			ctrl_write(wd);
			apb_xfer(1'b0, elk_io_pkg::reg_ctrl_addr, 32'd0, rsp);
			check_apb("ctrl read", expect_rsp(ctrl_word(), 1'b0), rsp, 1'b1);
		end
		// status is read-only
		apb_xfer(1'b1, elk_io_pkg::reg_status_addr, $random(seed), rsp);
		check_apb("status write", expect_rsp(32'd0, 1'b1), rsp, 1'b0);
		apb_xfer(1'b0, elk_io_pkg::reg_status_addr, 32'd0, rsp);
		check_apb("status read", expect_rsp(status_word(), 1'b0), rsp, 1'b1);
		bad = 8'h00;
		while (bad == 8'h00 || bad == 8'h04)
			bad = $random(seed);
		apb_xfer(1'b1, bad, $random(seed), rsp);
		check_apb("bad addr write", expect_rsp(32'd0, 1'b1), rsp, 1'b0);
		apb_xfer(1'b0, bad, 32'd0, rsp);
		check_apb("bad addr read", expect_rsp(32'd0, 1'b1), rsp, 1'b1);
		report_test("apb registers", err_start);
	endtask

	task automatic test_rom();
		int err_start;
		int s;
		int k;
		int la;
		err_start = errors;
		ctrl_write(32'h1);
		@(negedge clk_sys);
		check_bit("core_reset held", 1'b1, core_reset);
		// every slot at every shared offset
		for (s = 0; s < rom_slots; s++) begin
			for (k = 0; k < n_offs; k++) begin
				la = s * (1 << elk_mem_pkg::bank_addr_bits) + offs[k];
				rom_model[la] = $random(seed);
				rom_load_word(la, rom_model[la]);
			end
		end
		@(posedge clk_sys);
		rom_load.valid <= 1'b0;
		ctrl_write(32'h0);
		@(negedge clk_sys);
		check_bit("core_reset released", 1'b0, core_reset);
		map_reads("rom read", 16);
		// loader is ignored while the core runs
		for (k = 0; k < n_offs; k++) begin
			la = ($unsigned($random(seed)) % rom_slots) * (1 << elk_mem_pkg::bank_addr_bits);
			la = la + offs[k];
			rom_load_word(la, ~rom_model[la]);
		end
		@(posedge clk_sys);
		rom_load.valid <= 1'b0;
		map_reads("rom after ignored load", 16);
		report_test("rom load and read", err_start);
	endtask

	task automatic test_ram();
		int err_start;
		int s;
		int k;
		int i;
		err_start = errors;
		for (s = 0; s < ram_slots; s++) begin
			for (k = 0; k < n_offs; k++)
				ram_write(s, offs[k], $random(seed), 1);
		end
		// overwrites with longer strobes
		for (i = 0; i < ram_extra; i++) begin
			ram_write($random(seed), offs[$unsigned($random(seed)) % n_offs], $random(seed),
				1 + ($unsigned($random(seed)) % 4));
		end
		map_reads("map read", 32);
		report_test("ram writes and reads", err_start);
	endtask

	task automatic test_slicer();
		int                   err_start;
		int                   i;
		int                   s;
		int                   level;
		int                   amp;
		int                   run_left;
		logic                 file_bit;
		logic                 exp_cas;
		elk_io_pkg::apb_rsp_t rsp;
		err_start = errors;
		ctrl_write(32'h4);
		run_left = 0;
		for (i = 0; i < n_samples; i++) begin
			if (i == file_from)
				ctrl_write(32'h0);
			// new level run with its own noise depth
			if (run_left == 0) begin
				level    = $unsigned($random(seed)) % 4096;
				amp      = $unsigned($random(seed)) % 200;
				run_left = 8 + ($unsigned($random(seed)) % 120);
			end
			run_left--;
			s = level + ($random(seed) % (amp + 1));
			if (s < 0)
				s = 0;
			if (s > 4095)
				s = 4095;
			file_bit = $random(seed);
			exp_cas  = slice_step(s);
			@(posedge clk_sys);
			adc_in.valid  <= 1'b1;
			adc_in.data   <= s[11:0];
			tape_file_bit <= file_bit;
			@(posedge clk_sys);
			adc_in.valid  <= 1'b0;
			@(negedge clk_sys);
			check_bit("tape_in", cfg_model.tape_from_adc ? exp_cas : file_bit, tape_in);
			apb_xfer(1'b0, elk_io_pkg::reg_status_addr, 32'd0, rsp);
			check_apb("status cas_bit", expect_rsp(status_word(), 1'b0), rsp, 1'b1);
		end
		report_test("tape slicer", err_start);
	endtask

	task automatic test_joy();
		int                  err_start;
		int                  sw;
		int                  i;
		elk_io_pkg::joy_in_t ja;
		elk_io_pkg::joy_in_t jb;
		logic                file_bit;
		err_start = errors;
		for (sw = 0; sw < 2; sw++) begin
			ctrl_write(sw ? 32'h2 : 32'h0);
			for (i = 0; i < joy_vecs; i++) begin
				ja       = $random(seed);
				jb       = $random(seed);
				file_bit = $random(seed);
				@(posedge clk_sys);
				joy_a         <= ja;
				joy_b         <= jb;
				tape_file_bit <= file_bit;
				@(negedge clk_sys);
				check_joy("joy_1", expect_joy(sw ? jb : ja), joy_1);
				check_joy("joy_2", expect_joy(sw ? ja : jb), joy_2);
				check_bit("tape_in file", file_bit, tape_in);
			end
		end
		report_test("joystick routing", err_start);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		seed         = 32'h45fd;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		model_reset();
		rst_n         <= 1'b0;
		apb_req       <= '0;
		mem_req       <= {19'd0, 1'b1, 8'h00};
		rom_load      <= '0;
		adc_in        <= '0;
		tape_file_bit <= 1'b0;
		joy_a         <= '0;
		joy_b         <= '0;
		repeat (4) @(posedge clk_sys);
		rst_n <= 1'b1;
		foreach (offs[k])
			offs[k] = $random(seed);
		test_regs();
		test_rom();
		test_ram();
		test_slicer();
		test_joy();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+sim
hw/elk_mem_pkg.sv
hw/elk_io_pkg.sv
hw/elk_ctrl_regs.sv
hw/elk_mem_map.sv
hw/elk_tape_slicer.sv
hw/elk_input_router.sv
hw/elk_glue_top.sv
sim/elk_glue_tb.sv
